// File: load_store_unit.f
logic/ls_pkg.sv
logic/ls_req_if.sv
logic/ls_addr_gen.sv
logic/ls_request_queue.sv
logic/ls_data_mem.sv
logic/ls_load_format.sv
logic/load_store_unit.sv
verif/tb_clock_gen.sv
verif/load_store_unit_tb.sv

// File: Makefile
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := load_store_unit_tb
RTL_TOP    := load_store_unit
FILELIST   := load_store_unit.f
OBJ_DIR    := obj_dir
SIM        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the simulation printed the pass line
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verif/load_store_unit_tb.sv
/*
  Table-driven testbench for the load/store unit.
  Keeps a little-endian byte model of the local memory and checks every
  writeback in issue order, every exception and the issue back-pressure.
  Rows only read memory bytes that earlier rows have written.
  Inputs change 1 time unit after the rising edge, writebacks are
  sampled on the falling edge.
*/
module load_store_unit_tb;
    import ls_pkg::*;

    localparam xlen_t MEM_BASE = DEFAULT_MEM_BASE;
    localparam int MEM_WORDS = DEFAULT_MEM_WORDS;
    localparam int QUEUE_DEPTH = DEFAULT_QUEUE_DEPTH;
    localparam int WAIT_LIMIT = 50;
    // Cycles without issue_ready under held writeback that count as a stall
    localparam int STALL_CYCLES = 8;
    localparam int BURST_GROUP = 5;
    localparam int BURST_LOADS = QUEUE_DEPTH + 3;

    localparam logic ST = 1'b1;
    localparam logic LD = 1'b0;
    localparam logic [3:0] NO_EXC = 4'd0;

    // Row modes
    localparam logic [2:0] M_FIXED = 3'd0;
    localparam logic [2:0] M_RDATA = 3'd1;
    localparam logic [2:0] M_ROFF = 3'd2;
    localparam logic [2:0] M_SAME = 3'd3;
    localparam logic [2:0] M_HOLD = 3'd4;

    typedef struct packed {
        logic [2:0] group;
        logic is_store;
        ls_size_e size;
        xlen_t rs1;
        logic signed [31:0] off;
        xlen_t rs2;
        ls_id_t id;
        logic [3:0] exc_code;
        logic [2:0] mode;
    } row_t;

    logic clk;
    logic rst;
    logic issue_valid;
    logic issue_load;
    logic issue_store;
    ls_size_e issue_size;
    xlen_t issue_rs1;
    offset_t issue_offset;
    xlen_t issue_rs2;
    ls_id_t issue_id;
    logic issue_ready;
    logic exception_valid;
    exc_code_e exception_code;
    xlen_t exception_tval;
    ls_id_t exception_id;
    logic exception_ack;
    logic wb_valid;
    ls_id_t wb_id;
    xlen_t wb_data;
    logic wb_ready;
    logic idle;

    row_t stim_table[$];
    xlen_t exp_data_q[$];
    ls_id_t exp_id_q[$];
    logic [7:0] mem_model [4*MEM_WORDS];

    logic [15:0] lfsr_state = 16'd88;
    int last_off;
    int errors;
    int checks;
    int wb_count;
    int group_start_errors;
    int burst_count;
    int stall_accepts;
    bit stall_seen;
    bit aborted;

    tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(5)) i_clock_gen (.clk(clk), .rst(rst));

    load_store_unit #(
        .MEM_BASE(MEM_BASE),
        .MEM_WORDS(MEM_WORDS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue_load(issue_load),
        .issue_store(issue_store),
        .issue_size(issue_size),
        .issue_rs1(issue_rs1),
        .issue_offset(issue_offset),
        .issue_rs2(issue_rs2),
        .issue_id(issue_id),
        .issue_ready(issue_ready),
        .exception_valid(exception_valid),
        .exception_code(exception_code),
        .exception_tval(exception_tval),
        .exception_id(exception_id),
        .exception_ack(exception_ack),
        .wb_valid(wb_valid),
        .wb_id(wb_id),
        .wb_data(wb_data),
        .wb_ready(wb_ready),
        .idle(idle)
    );

    //////////////////////////////////////////////////////////////////////
    // Helpers

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_bits(input int count, output xlen_t value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int access_bytes(input ls_size_e size);
        case (size)
            LS_B, L_BU: return 1;
            LS_H, L_HU: return 2;
            default: return 4;
        endcase
    endfunction

    function automatic int align_mask(input ls_size_e size);
        return -access_bytes(size);
    endfunction

    // Little endian, sign or zero extension by funct3
    function automatic xlen_t load_value(input xlen_t addr, input ls_size_e size);
        int idx;
        idx = int'(addr - MEM_BASE);
        case (size)
            LS_B: return {{24{mem_model[idx][7]}}, mem_model[idx]};
            L_BU: return {24'h0, mem_model[idx]};
            LS_H: return {{16{mem_model[idx + 1][7]}}, mem_model[idx + 1], mem_model[idx]};
            L_HU: return {16'h0, mem_model[idx + 1], mem_model[idx]};
            default: return {mem_model[idx + 3], mem_model[idx + 2],
                             mem_model[idx + 1], mem_model[idx]};
        endcase
    endfunction

    task automatic store_model(input xlen_t addr, input ls_size_e size, input xlen_t data);
        int idx;
        idx = int'(addr - MEM_BASE);
        for (int i = 0; i < access_bytes(size); i++) begin
            mem_model[idx + i] = data[8*i +: 8];
        end
    endtask

    function automatic string group_name(input int group);
        case (group)
            1: return "word store then load";
            2: return "byte and halfword lanes";
            3: return "misaligned access";
            4: return "out-of-range access";
            default: return "queue back-pressure";
        endcase
    endfunction

    task automatic expect_equal(input string what, input xlen_t got, input xlen_t exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("Timed out waiting for %s at time %0t", what, $time);
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!idle && !aborted) begin
            if (waited == WAIT_LIMIT) begin
                report_timeout("idle");
            end else begin
                tick();
                waited++;
            end
        end
    endtask

    task automatic add_row(input int group, input logic is_store, input ls_size_e size,
                           input xlen_t rs1, input int off, input xlen_t rs2, input int id,
                           input logic [3:0] exc_code, input logic [2:0] mode);
        row_t row;
        row.group = 3'(group);
        row.is_store = is_store;
        row.size = size;
        row.rs1 = rs1;
        row.off = off;
        row.rs2 = rs2;
        row.id = 4'(id);
        row.exc_code = exc_code;
        row.mode = mode;
        stim_table.push_back(row);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus table

    task automatic build_table();
        logic [7:0] byte_val;
        add_row(1, ST, LS_W, MEM_BASE, 'h40, 0, 1, NO_EXC, M_RDATA);
        add_row(1, LD, LS_W, MEM_BASE, 'h40, 0, 2, NO_EXC, M_FIXED);
        add_row(1, ST, LS_W, MEM_BASE, 0, 0, 3, NO_EXC, M_ROFF);
        add_row(1, LD, LS_W, MEM_BASE, 0, 0, 4, NO_EXC, M_SAME);
        add_row(1, ST, LS_W, MEM_BASE + 'h100, -4, 0, 5, NO_EXC, M_RDATA);
        add_row(1, LD, LS_W, MEM_BASE + 'h0F0, 'h0C, 0, 6, NO_EXC, M_FIXED);

        add_row(2, ST, LS_W, MEM_BASE, 'h80, 0, 1, NO_EXC, M_RDATA);
        for (int lane = 0; lane < 4; lane++) begin
            // Sign bit of the stored byte alternates by lane
            byte_val = (lane % 2 == 0) ? 8'h80 + 8'(lane) : 8'h7F - 8'(lane);
            add_row(2, ST, LS_B, MEM_BASE, 'h80 + lane, {24'hA5C3E1, byte_val},
                    2 + 3*lane, NO_EXC, M_FIXED);
            add_row(2, LD, LS_B, MEM_BASE, 'h80 + lane, 0, 3 + 3*lane, NO_EXC, M_FIXED);
            add_row(2, LD, L_BU, MEM_BASE, 'h80 + lane, 0, 4 + 3*lane, NO_EXC, M_FIXED);
        end
        add_row(2, LD, LS_W, MEM_BASE, 'h80, 0, 14, NO_EXC, M_FIXED);
        add_row(2, ST, LS_W, MEM_BASE, 'h84, 0, 15, NO_EXC, M_RDATA);
        add_row(2, ST, LS_H, MEM_BASE, 'h84, 32'h1234_8001, 0, NO_EXC, M_FIXED);
        add_row(2, LD, LS_H, MEM_BASE, 'h84, 0, 1, NO_EXC, M_FIXED);
        add_row(2, LD, L_HU, MEM_BASE, 'h84, 0, 2, NO_EXC, M_FIXED);
        add_row(2, ST, LS_H, MEM_BASE, 'h86, 32'h8765_7FFE, 3, NO_EXC, M_FIXED);
        add_row(2, LD, LS_H, MEM_BASE, 'h86, 0, 4, NO_EXC, M_FIXED);
        add_row(2, LD, L_HU, MEM_BASE, 'h86, 0, 5, NO_EXC, M_FIXED);
        add_row(2, LD, LS_W, MEM_BASE, 'h84, 0, 6, NO_EXC, M_FIXED);

        add_row(3, LD, LS_H, MEM_BASE + 'h80, 5, 0, 7, LOAD_ADDR_MISALIGNED, M_FIXED);
        add_row(3, ST, LS_W, MEM_BASE + 'h80, 2, 32'hDEAD_BEEF, 8, STORE_ADDR_MISALIGNED,
                M_FIXED);
        add_row(3, LD, LS_W, MEM_BASE, 'h80, 0, 9, NO_EXC, M_FIXED);
        add_row(3, LD, LS_W, MEM_BASE, 'h84, 0, 10, NO_EXC, M_FIXED);

        add_row(4, LD, LS_W, MEM_BASE, -4, 0, 11, LOAD_FAULT, M_FIXED);
        add_row(4, ST, LS_W, MEM_BASE + 4*MEM_WORDS, 0, 32'h0BAD_F00D, 12, STORE_FAULT,
                M_FIXED);
        add_row(4, LD, L_BU, MEM_BASE + 4*MEM_WORDS - 1, 1, 0, 13, LOAD_FAULT, M_FIXED);
        add_row(4, ST, LS_B, 32'h0, 'h10, 32'h55, 14, STORE_FAULT, M_FIXED);
        // Misalignment wins over the range fault
        add_row(4, LD, LS_W, MEM_BASE, -2, 0, 15, LOAD_ADDR_MISALIGNED, M_FIXED);

        for (int k = 0; k < BURST_LOADS; k++) begin
            add_row(5, ST, LS_W, MEM_BASE + 'h200, 4*k, 0, k, NO_EXC, M_RDATA);
        end
        for (int k = 0; k < BURST_LOADS; k++) begin
            add_row(5, LD, LS_W, MEM_BASE + 'h200, 4*k, 0, 8 + k, NO_EXC,
                    (k == 0) ? M_HOLD : M_FIXED);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Row driver

    task automatic run_row(input row_t row);
        xlen_t rs2;
        xlen_t rbits;
        xlen_t addr;
        int off;
        int waited;
        if (row.mode == M_HOLD) begin
            wait_idle();
            wb_ready = 1'b0;
            burst_count = 0;
        end
        rs2 = row.rs2;
        if (row.mode == M_RDATA || row.mode == M_ROFF) begin
            draw_bits(32, rs2);
        end
        off = int'(row.off);
        if (row.mode == M_ROFF) begin
            draw_bits(10, rbits);
            last_off = int'(rbits) & align_mask(row.size);
        end
        if (row.mode == M_ROFF || row.mode == M_SAME) begin
            off = last_off;
        end
        addr = row.rs1 + xlen_t'(off);

        issue_valid = 1'b1;
        issue_load = ~row.is_store;
        issue_store = row.is_store;
        issue_size = row.size;
        issue_rs1 = row.rs1;
        issue_offset = 12'(off);
        issue_rs2 = rs2;
        issue_id = row.id;

        waited = 0;
        while (!issue_ready && !aborted) begin
            // Held writeback has backed up the queue, let it drain
            if (!wb_ready && waited >= STALL_CYCLES) begin
                stall_seen = 1'b1;
                stall_accepts = burst_count;
                wb_ready = 1'b1;
            end
            if (waited == WAIT_LIMIT) begin
                report_timeout("issue_ready");
            end else begin
                tick();
                waited++;
            end
        end
        if (aborted) begin
            issue_valid = 1'b0;
            return;
        end
        tick();
        issue_valid = 1'b0;
        // The accepted request now sits in the queue or the exception register
        expect_equal("idle after issue", 32'(idle), 0);
        if (!wb_ready) begin
            burst_count++;
        end

        if (row.exc_code != NO_EXC) begin
            expect_equal("exception_valid", 32'(exception_valid), 1);
            expect_equal("exception_code", 32'(exception_code), 32'(row.exc_code));
            expect_equal("exception_tval", exception_tval, addr);
            expect_equal("exception_id", 32'(exception_id), 32'(row.id));
            repeat (2) begin
                expect_equal("issue_ready while exception pending", 32'(issue_ready), 0);
                tick();
            end
            expect_equal("exception_valid before ack", 32'(exception_valid), 1);
            exception_ack = 1'b1;
            tick();
            exception_ack = 1'b0;
            expect_equal("exception_valid after ack", 32'(exception_valid), 0);
        end else begin
            expect_equal("exception_valid", 32'(exception_valid), 0);
            if (row.is_store) begin
                store_model(addr, row.size, rs2);
            end else begin
                exp_data_q.push_back(load_value(addr, row.size));
                exp_id_q.push_back(row.id);
            end
        end
    endtask

    task automatic finish_group(input int group);
        wait_idle();
        expect_equal("loads without writeback", 32'(exp_id_q.size()), 0);
        if (group == BURST_GROUP) begin
            checks++;
            assert (stall_seen)
            else begin
                errors++;
                $display("Issue never stalled while writeback was held low");
            end
            expect_equal("loads accepted before stall", 32'(stall_accepts), QUEUE_DEPTH + 1);
        end
        $display("Test %0d %s: %0d errors", group, group_name(group),
                 errors - group_start_errors);
        group_start_errors = errors;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Writeback monitor

    always @(negedge clk) begin
        if (!rst && wb_valid && wb_ready) begin
            wb_count++;
            checks++;
            assert (exp_id_q.size() != 0)
            else begin
                errors++;
                $display("Writeback with id %0d arrived but no load was outstanding", wb_id);
            end
            if (exp_id_q.size() != 0) begin
                expect_equal("wb_id", 32'(wb_id), 32'(exp_id_q.pop_front()));
                expect_equal("wb_data", wb_data, exp_data_q.pop_front());
            end
        end
    end

    // Main sequence
    initial begin
        int waited;
        issue_valid = 1'b0;
        issue_load = 1'b0;
        issue_store = 1'b0;
        issue_size = LS_W;
        issue_rs1 = '0;
        issue_offset = '0;
        issue_rs2 = '0;
        issue_id = '0;
        exception_ack = 1'b0;
        wb_ready = 1'b1;
        build_table();

        waited = 0;
        tick();
        while (rst && !aborted) begin
            if (waited == WAIT_LIMIT) begin
                report_timeout("reset release");
            end else begin
                tick();
                waited++;
            end
        end

        for (int r = 0; r < stim_table.size(); r++) begin
            if (!aborted) begin
                run_row(stim_table[r]);
            end
            if (r == stim_table.size() - 1 || stim_table[r + 1].group != stim_table[r].group) begin
                finish_group(int'(stim_table[r].group));
            end
        end

        $display("Checks: %0d, errors: %0d, writebacks: %0d", checks, errors, wb_count);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/tb_clock_gen.sv
/*
  Free-running testbench clock and a synchronous active-high reset.
  Reset is released with a nonblocking update on a rising edge, after
  RESET_CYCLES edges.
*/
module tb_clock_gen #(
    parameter int PERIOD = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: logic/load_store_unit.sv
/*
  Load/store unit top level.
  Issue and writeback use valid/ready. An exception stays up until acked
  and blocks further issue meanwhile. Results return strictly in order.
  MEM_WORDS and QUEUE_DEPTH must be powers of two of at least 2, and
  MEM_BASE must be word aligned.
*/
module load_store_unit #(
    parameter ls_pkg::xlen_t MEM_BASE = ls_pkg::DEFAULT_MEM_BASE,
    parameter int MEM_WORDS = ls_pkg::DEFAULT_MEM_WORDS,
    parameter int QUEUE_DEPTH = ls_pkg::DEFAULT_QUEUE_DEPTH
) (
    input logic clk,
    input logic rst,

    input logic issue_valid,
    input logic issue_load,
    input logic issue_store,
    input ls_pkg::ls_size_e issue_size,
    input ls_pkg::xlen_t issue_rs1,
    input ls_pkg::offset_t issue_offset,
    input ls_pkg::xlen_t issue_rs2,
    input ls_pkg::ls_id_t issue_id,
    output logic issue_ready,

    output logic exception_valid,
    output ls_pkg::exc_code_e exception_code,
    output ls_pkg::xlen_t exception_tval,
    output ls_pkg::ls_id_t exception_id,
    input logic exception_ack,

    output logic wb_valid,
    output ls_pkg::ls_id_t wb_id,
    output ls_pkg::xlen_t wb_data,
    input logic wb_ready,

    output logic idle
);
    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic queue_empty;
    logic fmt_busy;
    ls_pkg::xlen_t rdata;

    ls_req_if #(.ADDR_W(ADDR_W)) gen_to_queue ();
    ls_req_if #(.ADDR_W(ADDR_W)) queue_to_mem ();

    ///////////////////////////////////////////////////////////////////////
    // Producer

    ls_addr_gen #(
        .MEM_BASE(MEM_BASE),
        .MEM_WORDS(MEM_WORDS)
    ) i_addr_gen (
        .clk(clk),
        .rst(rst),
        .issue_valid(issue_valid),
        .issue_load(issue_load),
        .issue_store(issue_store),
        .issue_size(issue_size),
        .issue_rs1(issue_rs1),
        .issue_offset(issue_offset),
        .issue_rs2(issue_rs2),
        .issue_id(issue_id),
        .issue_ready(issue_ready),
        .exception_ack(exception_ack),
        .exception_valid(exception_valid),
        .exception_code(exception_code),
        .exception_tval(exception_tval),
        .exception_id(exception_id),
        .req(gen_to_queue.src)
    );

    // Buffer
    ls_request_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_queue (
        .clk(clk),
        .rst(rst),
        .in_req(gen_to_queue.sink),
        .out_req(queue_to_mem.src),
        .empty(queue_empty)
    );

    ///////////////////////////////////////////////////////////////////////
    // Consumer

    ls_data_mem #(
        .MEM_BASE(MEM_BASE),
        .MEM_WORDS(MEM_WORDS)
    ) i_data_mem (
        .clk(clk),
        .rst(rst),
        .req(queue_to_mem.sink),
        .rdata(rdata)
    );

    ls_load_format i_load_format (
        .clk(clk),
        .rst(rst),
        .req(queue_to_mem.observer),
        .rdata(rdata),
        .wb_valid(wb_valid),
        .wb_id(wb_id),
        .wb_data(wb_data),
        .wb_ready(wb_ready),
        .busy(fmt_busy)
    );

    assign idle = queue_empty & ~fmt_busy & ~exception_valid;

endmodule

// File: logic/ls_load_format.sv
/*
  Load result formatting and the writeback register.
  Captures size, byte offset and id of each accepted load. The memory read
  data arrives one cycle later and stays stable while writeback stalls,
  so the formatted value is built from it directly.
  Loads must be naturally aligned. Stores pass through without a result.
*/
module ls_load_format (
    input logic clk,
    input logic rst,
    ls_req_if.observer req,
    input ls_pkg::xlen_t rdata,
    output logic wb_valid,
    output ls_pkg::ls_id_t wb_id,
    output ls_pkg::xlen_t wb_data,
    input logic wb_ready,
    output logic busy
);
    import ls_pkg::*;

    ls_size_e size_r;
    logic [1:0] byte_addr_r;
    logic load_acc;
    logic [15:0] half_sel;
    logic [7:0] byte_sel;

    // Memory accepts only while the writeback slot is free or draining
    assign req.ready = ~wb_valid | wb_ready;
    assign load_acc = req.valid & req.ready & req.load;

    ///////////////////////////////////////////////////////////////////////
    // Writeback control

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (load_acc) begin
            wb_valid <= 1'b1;
        end else if (wb_ready) begin
            wb_valid <= 1'b0;
        end
    end

    // Load attributes
    always_ff @(posedge clk) begin
        if (load_acc) begin
            size_r <= req.size;
            byte_addr_r <= req.byte_addr;
            wb_id <= req.id;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Lane select then extend

    assign half_sel = byte_addr_r[1] ? rdata[31:16] : rdata[15:0];
    assign byte_sel = byte_addr_r[0] ? half_sel[15:8] : half_sel[7:0];

    always_comb begin
        case (size_r)
            LS_B: wb_data = {{24{byte_sel[7]}}, byte_sel};
            LS_H: wb_data = {{16{half_sel[15]}}, half_sel};
            L_BU: wb_data = {24'h0, byte_sel};
            L_HU: wb_data = {16'h0, half_sel};
            default: wb_data = rdata;
        endcase
    end

    assign busy = wb_valid;

    // A stalled result stays put, which relies on the memory holding rdata
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && !wb_ready) |=> (wb_valid && $stable(wb_data) && $stable(wb_id)));

endmodule

// File: logic/ls_data_mem.sv
/*
  Local data memory, one 32-bit word per entry, MEM_WORDS deep.
  Stores write their enabled lanes on the accepting edge.
  Loads return the addressed word on the next cycle and rdata holds until
  the next accepted load. Ready on the request comes from the writeback
  stage and is only observed here.
*/
module ls_data_mem #(
    parameter ls_pkg::xlen_t MEM_BASE = ls_pkg::DEFAULT_MEM_BASE,
    parameter int MEM_WORDS = ls_pkg::DEFAULT_MEM_WORDS
) (
    input logic clk,
    input logic rst,
    ls_req_if.sink req,
    output ls_pkg::xlen_t rdata
);
    import ls_pkg::*;

    xlen_t mem [MEM_WORDS];
    logic accept;

    assign accept = req.valid & req.ready;

    ///////////////////////////////////////////////////////////////////////
    // Byte-enabled write port

    always_ff @(posedge clk) begin
        if (accept && req.store) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.be[lane]) begin
                    mem[req.word_addr][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Read port
    always_ff @(posedge clk) begin
        if (accept && req.load) begin
            rdata <= mem[req.word_addr];
        end
    end

    // Word index arrives already relative to this base
    initial begin
        assert (MEM_BASE[1:0] == 2'b00);
    end

    // Every store that reaches memory writes at least one lane and is
    // not also a load
    a_store_lanes: assert property (@(posedge clk) disable iff (rst)
        (accept && req.store) |-> (req.be != '0 && !req.load));

endmodule

// File: logic/ls_request_queue.sv
/*
  In-order request FIFO between address generation and memory.
  QUEUE_DEPTH must be a power of two and at least 2.
  Ready toward the producer is registered and stays low during reset.
*/
module ls_request_queue #(
    parameter int QUEUE_DEPTH = ls_pkg::DEFAULT_QUEUE_DEPTH
) (
    input logic clk,
    input logic rst,
    ls_req_if.sink in_req,
    ls_req_if.src out_req,
    output logic empty
);
    import ls_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int ADDR_W = $bits(in_req.word_addr);

    logic [ADDR_W-1:0] word_addr_q [QUEUE_DEPTH];
    logic [1:0] byte_addr_q [QUEUE_DEPTH];
    byte_en_t be_q [QUEUE_DEPTH];
    xlen_t wdata_q [QUEUE_DEPTH];
    ls_size_e size_q [QUEUE_DEPTH];
    logic load_q [QUEUE_DEPTH];
    logic store_q [QUEUE_DEPTH];
    ls_id_t id_q [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic [PTR_W:0] count_next;
    logic push;
    logic pop;

    assign push = in_req.valid & in_req.ready;
    assign pop = out_req.valid & out_req.ready;
    assign count_next = count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);

    ///////////////////////////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_req.ready <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push);
            rd_ptr <= rd_ptr + PTR_W'(pop);
            count <= count_next;
            in_req.ready <= count_next != (PTR_W+1)'(QUEUE_DEPTH);
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            word_addr_q[wr_ptr] <= in_req.word_addr;
            byte_addr_q[wr_ptr] <= in_req.byte_addr;
            be_q[wr_ptr] <= in_req.be;
            wdata_q[wr_ptr] <= in_req.wdata;
            size_q[wr_ptr] <= in_req.size;
            load_q[wr_ptr] <= in_req.load;
            store_q[wr_ptr] <= in_req.store;
            id_q[wr_ptr] <= in_req.id;
        end
    end

    assign out_req.valid = count != '0;
    assign out_req.word_addr = word_addr_q[rd_ptr];
    assign out_req.byte_addr = byte_addr_q[rd_ptr];
    assign out_req.be = be_q[rd_ptr];
    assign out_req.wdata = wdata_q[rd_ptr];
    assign out_req.size = size_q[rd_ptr];
    assign out_req.load = load_q[rd_ptr];
    assign out_req.store = store_q[rd_ptr];
    assign out_req.id = id_q[rd_ptr];

    assign empty = count == '0;

    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> count != (PTR_W+1)'(QUEUE_DEPTH));

    // Head entry stays put while memory stalls
    a_head_hold: assert property (@(posedge clk) disable iff (rst)
        (out_req.valid && !out_req.ready) |=> (out_req.valid
            && $stable(out_req.word_addr) && $stable(out_req.wdata) && $stable(out_req.id)));

endmodule

// File: logic/ls_addr_gen.sv
/*
  Effective address generation and access checks.
  Outputs toward the queue are combinational from the issue inputs, so the
  issuer must hold its fields stable while issue_ready is low.
  A misaligned or out-of-range access never enters the queue. It loads the
  exception register and blocks issue until exception_ack.
  Misalignment wins over the range fault. MEM_BASE must be word aligned.
*/
module ls_addr_gen #(
    parameter ls_pkg::xlen_t MEM_BASE = ls_pkg::DEFAULT_MEM_BASE,
    parameter int MEM_WORDS = ls_pkg::DEFAULT_MEM_WORDS
) (
    input logic clk,
    input logic rst,

    input logic issue_valid,
    input logic issue_load,
    input logic issue_store,
    input ls_pkg::ls_size_e issue_size,
    input ls_pkg::xlen_t issue_rs1,
    input ls_pkg::offset_t issue_offset,
    input ls_pkg::xlen_t issue_rs2,
    input ls_pkg::ls_id_t issue_id,
    output logic issue_ready,

    input logic exception_ack,
    output logic exception_valid,
    output ls_pkg::exc_code_e exception_code,
    output ls_pkg::xlen_t exception_tval,
    output ls_pkg::ls_id_t exception_id,

    ls_req_if.src req
);
    import ls_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);
    localparam xlen_t MEM_BYTES = xlen_t'(4 * MEM_WORDS);

    xlen_t eff_addr;
    xlen_t rel_addr;
    logic misaligned;
    logic out_of_range;
    logic bad_addr;
    logic new_exc;
    byte_en_t be_lanes;

    ///////////////////////////////////////////////////////////////////////
    // Address and checks

    assign eff_addr = issue_rs1 + {{20{issue_offset[11]}}, issue_offset};
    assign rel_addr = eff_addr - MEM_BASE;

    always_comb begin
        case (issue_size)
            LS_H, L_HU: misaligned = eff_addr[0];
            LS_W: misaligned = |eff_addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Below base wraps rel_addr around to a large value as well
    assign out_of_range = (eff_addr < MEM_BASE) | (rel_addr >= MEM_BYTES);
    assign bad_addr = misaligned | out_of_range;

    ///////////////////////////////////////////////////////////////////////
    // Byte lanes

    always_comb begin
        be_lanes = '0;
        case (issue_size)
            LS_B, L_BU: be_lanes[eff_addr[1:0]] = 1'b1;
            LS_H, L_HU: be_lanes = eff_addr[1] ? 4'b1100 : 4'b0011;
            default: be_lanes = 4'b1111;
        endcase
    end

    always_comb begin
        case (issue_size)
            LS_B, L_BU: req.wdata = {4{issue_rs2[7:0]}};
            LS_H, L_HU: req.wdata = {2{issue_rs2[15:0]}};
            default: req.wdata = issue_rs2;
        endcase
    end

    // Loads carry no write lanes
    assign req.be = issue_store ? be_lanes : '0;
    assign req.word_addr = rel_addr[ADDR_W+1:2];
    assign req.byte_addr = eff_addr[1:0];
    assign req.size = issue_size;
    assign req.load = issue_load;
    assign req.store = issue_store;
    assign req.id = issue_id;

    assign req.valid = issue_valid & ~exception_valid & ~bad_addr;
    assign issue_ready = req.ready & ~exception_valid;

    ///////////////////////////////////////////////////////////////////////
    // Exception register

    assign new_exc = issue_valid & issue_ready & bad_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            exception_valid <= 1'b0;
        end else begin
            exception_valid <= (exception_valid & ~exception_ack) | new_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (new_exc) begin
            if (misaligned) begin
                exception_code <= issue_store ? STORE_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED;
            end else begin
                exception_code <= issue_store ? STORE_FAULT : LOAD_FAULT;
            end
            exception_tval <= eff_addr;
            exception_id <= issue_id;
        end
    end

    // The issuer keeps a request stable until the queue takes it
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        (req.valid && !req.ready) |=> (req.valid && $stable(req.word_addr)
            && $stable(req.wdata) && $stable(req.be) && $stable(req.id)));

endmodule

// File: logic/ls_req_if.sv
/*
  One memory request between pipeline stages, valid/ready handshake.
  The source holds valid and every field stable while ready is low.
  word_addr indexes words inside the local memory, so ADDR_W must match
  the log2 of the memory depth.
*/
interface ls_req_if #(
    parameter int ADDR_W = $clog2(ls_pkg::DEFAULT_MEM_WORDS)
);
    import ls_pkg::*;

    logic valid;
    logic ready;

    logic [ADDR_W-1:0] word_addr;
    logic [1:0] byte_addr;
    byte_en_t be;
    // Already replicated into its byte lanes
    xlen_t wdata;
    ls_size_e size;
    logic load;
    logic store;
    ls_id_t id;

    modport src (
        output valid, word_addr, byte_addr, be, wdata, size, load, store, id,
        input ready
    );

    modport sink (
        input valid, word_addr, byte_addr, be, wdata, size, load, store, id,
        output ready
    );

    // Sees the transfer and supplies ready on behalf of the writeback side
    modport observer (
        input valid, byte_addr, size, load, store, id,
        output ready
    );

endinterface

// File: logic/ls_pkg.sv
/*
  Shared widths, access sizes and exception codes for the load/store unit.
  Size encodings follow the RISC-V load/store funct3 field.
  Exception codes follow the RISC-V mcause values for memory accesses.
*/
package ls_pkg;

    ///////////////////////////////////////////////////////////////////////
    // Data widths

    typedef logic [31:0] xlen_t;
    typedef logic signed [11:0] offset_t;
    typedef logic [3:0] ls_id_t;
    typedef logic [3:0] byte_en_t;

    ///////////////////////////////////////////////////////////////////////
    // Access size (funct3)

    typedef enum logic [2:0] {
        LS_B = 3'b000,
        LS_H = 3'b001,
        LS_W = 3'b010,
        L_BU = 3'b100,
        L_HU = 3'b101
    } ls_size_e;

    ///////////////////////////////////////////////////////////////////////
    // Exception codes

    typedef enum logic [3:0] {
        LOAD_ADDR_MISALIGNED = 4'd4,
        LOAD_FAULT = 4'd5,
        STORE_ADDR_MISALIGNED = 4'd6,
        STORE_FAULT = 4'd7
    } exc_code_e;

    ///////////////////////////////////////////////////////////////////////
    // Defaults for the top-level parameters

    // Must stay word aligned
    localparam xlen_t DEFAULT_MEM_BASE = 32'h0000_1000;

    // Both depths must be powers of two
    localparam int DEFAULT_MEM_WORDS = 256;
    localparam int DEFAULT_QUEUE_DEPTH = 4;

endpackage
